/* fetch_unit.f */
verilog/isa_pkg.sv
verilog/fetch_pkg.sv
verilog/branch_predictor.sv
verilog/l1i_cache.sv
verilog/ifu.sv
verilog/fetch_top.sv
test/bus_memory.sv
test/fetch_tb.sv

/* run_sim.sh */
#!/bin/sh
# builds the fetch unit testbench with verilator and runs it.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module fetch_tb -f fetch_unit.f \
  --Mdir obj_dir -o fetch_tb_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/fetch_tb_sim > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
  echo "simulation exited with status $run_status"
  exit 1
fi

if grep -q "^TB PASSED$" sim.log; then
  echo "result: pass"
  exit 0
fi
echo "result: fail"
exit 1

/* test/bus_memory.sv */
`default_nettype none

module bus_memory (
  input  wire                      clock,
  input  wire                      reset,
  input  logic [isa_pkg::xlen-1:0] image [256],
  input  wire  [isa_pkg::xlen-1:0] araddr,
  input  wire                      arvalid,
  output logic                     ready,
  output logic [isa_pkg::xlen-1:0] rdata,
  output logic                     rvalid
);

  logic                     took;  // request accepted on the last edge.
  logic [isa_pkg::xlen-1:0] addr_q;
  logic                     busy;
  int                       delay;

  always @(posedge clock) begin
    if (reset) begin
      took <= 1'b0;
    end else begin
      took <= arvalid && ready;
      if (arvalid && ready) begin
        addr_q <= araddr;
      end
    end
  end

  // ----------------------------------------
  // response side, falling edge
  // ----------------------------------------

  initial begin
    ready  = 1'b0;
    rvalid = 1'b0;
    rdata  = '0;
    busy   = 1'b0;
    delay  = 0;
    forever begin
      @(negedge clock);
      rvalid = 1'b0;  // one cycle pulse.
      if (took) begin
        busy  = 1'b1;
        ready = 1'b0;
        delay = $urandom_range(0, 4);
      end
      if (busy) begin
        if (delay == 0) begin
          rvalid = 1'b1;
          rdata  = image[addr_q[9:2]];
          busy   = 1'b0;
        end else begin
          delay = delay - 1;
        end
      end else begin
        ready = ($urandom_range(0, 3) != 0);
      end
    end
  end

endmodule

`default_nettype wire

/* test/fetch_tb.sv */
`default_nettype none

module fetch_tb;

  localparam int mem_words     = 256;
  localparam int run_transfers = 3000;
  localparam int stall_limit   = 200;
  localparam int ph_idle       = 0;
  localparam int ph_req        = 1;
  localparam int ph_wait       = 2;
  localparam int ph_settle     = 3;

  logic                     clock = 1'b0;
  logic                     reset;
  logic [isa_pkg::xlen-1:0] npc;
  logic [isa_pkg::xlen-1:0] cpc;
  logic                     br_retire;
  logic                     prev_valid;
  logic                     next_ready;
  logic                     flush_pipeline;
  logic                     fence_i;
  logic                     bus_ready;
  logic [isa_pkg::xlen-1:0] bus_rdata;
  logic                     bus_rvalid;
  logic [isa_pkg::xlen-1:0] inst;
  logic [isa_pkg::xlen-1:0] pc;
  logic [isa_pkg::xlen-1:0] pnpc;
  logic                     fetch_valid;
  logic                     ready;
  logic [isa_pkg::xlen-1:0] bus_araddr;
  logic                     bus_arvalid;
  logic                     bus_lock;

  // ----------------------------------------
  // reference model state
  // ----------------------------------------

  logic [isa_pkg::xlen-1:0]             image    [mem_words];
  logic [isa_pkg::xlen-1:0]             tab_b    [fetch_pkg::btb_entries];
  logic [isa_pkg::xlen-1:0]             tab_jal  [fetch_pkg::btb_entries];
  logic                                 line_ok  [fetch_pkg::cache_lines];
  logic [fetch_pkg::cache_tag_bits-1:0] line_tag [fetch_pkg::cache_lines];
  logic [isa_pkg::xlen-1:0] exp_pc;
  logic [isa_pkg::xlen-1:0] req_addr;
  logic [isa_pkg::xlen-1:0] flush_cpc;
  logic [isa_pkg::xlen-1:0] held_inst;
  logic [isa_pkg::xlen-1:0] held_pc;
  logic [isa_pkg::xlen-1:0] held_pnpc;
  logic held;       // last cycle was stalled with valid data.
  logic hazard;
  logic spec_b;
  logic drop_fill;
  logic flush_due;
  int   phase;
  int   retire_wait;
  int   transfers;
  int   idle_cycles;
  int   mismatches;
  int   failures;

  always #10 clock = ~clock;

  fetch_top fetch_top_inst (
    .clock(clock), .reset(reset), .npc(npc), .cpc(cpc), .br_retire(br_retire),
    .prev_valid(prev_valid), .next_ready(next_ready), .flush_pipeline(flush_pipeline),
    .fence_i(fence_i), .bus_ready(bus_ready), .bus_rdata(bus_rdata), .bus_rvalid(bus_rvalid),
    .inst(inst), .pc(pc), .pnpc(pnpc), .fetch_valid(fetch_valid), .ready(ready),
    .bus_araddr(bus_araddr), .bus_arvalid(bus_arvalid), .bus_lock(bus_lock)
  );

  bus_memory bus_memory_inst (
    .clock(clock), .reset(reset), .image(image), .araddr(bus_araddr),
    .arvalid(bus_arvalid), .ready(bus_ready), .rdata(bus_rdata), .rvalid(bus_rvalid)
  );

  function automatic logic [isa_pkg::xlen-1:0] word_at(input logic [isa_pkg::xlen-1:0] addr);
    return image[addr[9:2]];
  endfunction

  function automatic logic line_hit(input logic [isa_pkg::xlen-1:0] addr);
    logic [fetch_pkg::cache_index_bits-1:0] idx;
    idx = addr[fetch_pkg::cache_index_lsb +: fetch_pkg::cache_index_bits];
    return line_ok[idx] &&
           (line_tag[idx] == addr[fetch_pkg::cache_tag_lsb +: fetch_pkg::cache_tag_bits]);
  endfunction

  // backward taken, forward not taken.
  function automatic logic [isa_pkg::xlen-1:0] next_pc_of(input logic [isa_pkg::xlen-1:0] addr,
                                                          input logic [isa_pkg::xlen-1:0] word);
    logic [fetch_pkg::btb_index_bits-1:0] idx;
    idx = addr[fetch_pkg::btb_index_lsb +: fetch_pkg::btb_index_bits];
    if (word[6:0] == isa_pkg::op_branch && tab_b[idx] < addr) return tab_b[idx];
    if (word[6:0] == isa_pkg::op_jal && tab_jal[idx] < addr) return tab_jal[idx];
    return addr + 32'd4;
  endfunction

  function automatic logic [isa_pkg::xlen-1:0] random_target();
    return 32'($urandom_range(0, mem_words - 1)) << 2;
  endfunction

  function automatic logic [6:0] random_opcode();
    case ($urandom_range(0, 5))
      0: return isa_pkg::op_lui;
      1: return isa_pkg::op_op_imm;
      2: return isa_pkg::op_jal;
      3: return isa_pkg::op_jalr;
      4: return isa_pkg::op_branch;
      default: return isa_pkg::op_system;
    endcase
  endfunction

  task automatic compare_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
    if (actual !== expected) begin
      mismatches++;
      $display("MISMATCH %s: got %h, expected %h at %0t", name, actual, expected, $time);
    end
  endtask

  // ----------------------------------------
  // checks and model update at each edge
  // ----------------------------------------

  task automatic sample_edge();
    logic [isa_pkg::xlen-1:0] word;
    logic [isa_pkg::xlen-1:0] want_pnpc;
    logic [fetch_pkg::cache_index_bits-1:0] fill_idx;
    logic [fetch_pkg::btb_index_bits-1:0]   cpc_idx;
    logic [6:0] op;
    logic       want_valid;
    logic       accepted;
    logic       taken_b;
    int         next_phase;
    int         i;
    word       = word_at(exp_pc);
    op         = word[6:0];
    want_pnpc  = next_pc_of(exp_pc, word);
    taken_b    = (op == isa_pkg::op_branch) && (want_pnpc != exp_pc + 32'd4);
    want_valid = (phase == ph_idle) && line_hit(exp_pc) && !hazard && !flush_pipeline;
    accepted   = want_valid && next_ready;
    compare_value("fetch_valid", 32'(fetch_valid), 32'(want_valid));
    compare_value("ready", 32'(ready), 32'(!want_valid));
    compare_value("bus_lock", 32'(bus_lock), 32'(phase == ph_req || phase == ph_wait));
    if (held) begin
      compare_value("held fetch_valid", 32'(fetch_valid), 32'd1);
      compare_value("held inst", inst, held_inst);
      compare_value("held pc", pc, held_pc);
      compare_value("held pnpc", pnpc, held_pnpc);
    end
    if (fetch_valid) begin
      compare_value("pc", pc, exp_pc);
      compare_value("inst", inst, word);
      compare_value("pnpc", pnpc, want_pnpc);
    end
    held      = want_valid && !next_ready;
    held_inst = inst;
    held_pc   = pc;
    held_pnpc = pnpc;

    next_phase = phase;
    case (phase)
      ph_idle: begin
        compare_value("bus_arvalid", 32'(bus_arvalid), 32'd0);
        if (!line_hit(exp_pc) && !flush_pipeline && !fence_i) begin
          next_phase = ph_req;
          req_addr   = {exp_pc[isa_pkg::xlen-1:2], 2'b00};
        end
      end
      ph_req: begin
        compare_value("bus_arvalid", 32'(bus_arvalid), 32'd1);
        compare_value("bus_araddr", bus_araddr, req_addr);
        if (bus_ready) next_phase = ph_wait;
      end
      ph_wait: begin
        compare_value("bus_arvalid", 32'(bus_arvalid), 32'd0);
        if (bus_rvalid) next_phase = ph_settle;
      end
      default: begin
        compare_value("bus_arvalid", 32'(bus_arvalid), 32'd0);
        next_phase = ph_idle;
      end
    endcase
    if (fence_i) begin
      for (i = 0; i < fetch_pkg::cache_lines; i++) line_ok[i] = 1'b0;
      if (phase == ph_req || phase == ph_wait) drop_fill = 1'b1;  // line stays invalid.
    end
    if (phase == ph_wait && bus_rvalid) begin
      fill_idx           = req_addr[fetch_pkg::cache_index_lsb +: fetch_pkg::cache_index_bits];
      line_ok[fill_idx]  = !drop_fill;
      line_tag[fill_idx] = req_addr[fetch_pkg::cache_tag_lsb +: fetch_pkg::cache_tag_bits];
      drop_fill          = 1'b0;
    end
    phase = next_phase;

    if (flush_pipeline) begin
      cpc_idx = cpc[fetch_pkg::btb_index_lsb +: fetch_pkg::btb_index_bits];
      if (spec_b) tab_b[cpc_idx] = npc;
      else tab_jal[cpc_idx] = npc;
      exp_pc = npc;
      hazard = 1'b0;
      spec_b = 1'b0;
    end else begin
      if (br_retire && prev_valid) begin
        if (hazard) exp_pc = npc;
        hazard = 1'b0;
        spec_b = 1'b0;
      end
      if (accepted) begin
        transfers++;
        if (op == isa_pkg::op_system) begin
          hazard      = 1'b1;
          retire_wait = $urandom_range(1, 4);
        end else begin
          if ((op == isa_pkg::op_branch || op == isa_pkg::op_jal || op == isa_pkg::op_jalr)
              && $urandom_range(0, 2) == 0) begin
            flush_due = 1'b1;  // back end resolves a misprediction.
            flush_cpc = exp_pc;
          end
          exp_pc = want_pnpc;
        end
        if (taken_b) spec_b = 1'b1;
      end
    end
    idle_cycles = accepted ? 0 : idle_cycles + 1;
  endtask

  task automatic drive_back_end();
    flush_pipeline = 1'b0;
    br_retire      = 1'b0;
    prev_valid     = 1'b0;
    fence_i        = 1'b0;
    next_ready     = ($urandom_range(0, 3) != 0);
    if (flush_due) begin
      flush_pipeline = 1'b1;
      npc            = random_target();
      cpc            = flush_cpc;
      flush_due      = 1'b0;
    end else if (hazard) begin
      if (retire_wait == 0) begin
        br_retire  = 1'b1;
        prev_valid = 1'b1;
        npc        = random_target();
      end else begin
        retire_wait--;
      end
    end else if ($urandom_range(0, 39) == 0) begin
      fence_i    = 1'b1;
      next_ready = 1'b1;  // a stalled word is never fenced away.
    end
  endtask

  initial begin
    logic [isa_pkg::xlen-1:0] bits;
    int i;
    void'($urandom(58));
    for (i = 0; i < mem_words; i++) begin
      bits     = $urandom();
      image[i] = {bits[isa_pkg::xlen-1:7], random_opcode()};
    end
    for (i = 0; i < fetch_pkg::btb_entries; i++) begin
      tab_b[i]   = isa_pkg::pc_init;
      tab_jal[i] = isa_pkg::pc_init;
    end
    for (i = 0; i < fetch_pkg::cache_lines; i++) begin
      line_ok[i]  = 1'b0;
      line_tag[i] = '0;
    end
    exp_pc      = isa_pkg::pc_init;
    req_addr    = '0;
    flush_cpc   = '0;
    held        = 1'b0;
    hazard      = 1'b0;
    spec_b      = 1'b0;
    drop_fill   = 1'b0;
    flush_due   = 1'b0;
    phase       = ph_idle;
    retire_wait = 0;
    transfers   = 0;
    idle_cycles = 0;
    mismatches  = 0;
    failures    = 0;

    reset          = 1'b1;
    npc            = '0;
    cpc            = '0;
    br_retire      = 1'b0;
    prev_valid     = 1'b0;
    next_ready     = 1'b0;
    flush_pipeline = 1'b0;
    fence_i        = 1'b0;
    repeat (2) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;
    compare_value("fetch_valid after reset", 32'(fetch_valid), 32'd0);
    compare_value("bus_arvalid after reset", 32'(bus_arvalid), 32'd0);
    next_ready = 1'b1;

    while (transfers < run_transfers && idle_cycles < stall_limit) begin
      @(posedge clock);
      sample_edge();
      @(negedge clock);
      drive_back_end();
    end
    if (idle_cycles >= stall_limit) begin
      failures++;
      $display("no instruction was accepted for %0d cycles, expected pc %h", stall_limit, exp_pc);
    end

    $display("summary: %0d transfers, %0d mismatches, %0d other errors",
             transfers, mismatches, failures);
    if (mismatches == 0 && failures == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verilog/branch_predictor.sv */
`default_nettype none

module branch_predictor (
  input  wire                      clock,
  input  wire                      reset,
  input  wire  [isa_pkg::xlen-1:0] pc,
  input  wire                      is_branch_b,
  input  wire                      is_jal,
  input  wire                      update,
  input  wire  [isa_pkg::xlen-1:0] update_cpc,
  input  wire  [isa_pkg::xlen-1:0] update_target,
  input  wire                      update_b,
  output logic [isa_pkg::xlen-1:0] pnpc,
  output logic                     predict_taken,
  output logic                     predict_b
);

  logic [isa_pkg::xlen-1:0] btb_b   [fetch_pkg::btb_entries];  // conditional branches.
  logic [isa_pkg::xlen-1:0] btb_jal [fetch_pkg::btb_entries];

  logic [fetch_pkg::btb_index_bits-1:0] pc_idx;
  logic [fetch_pkg::btb_index_bits-1:0] cpc_idx;
  logic [isa_pkg::xlen-1:0]             target_b;
  logic [isa_pkg::xlen-1:0]             target_jal;
  logic                                 take_jal;

  assign pc_idx  = pc[fetch_pkg::btb_index_lsb +: fetch_pkg::btb_index_bits];
  assign cpc_idx = update_cpc[fetch_pkg::btb_index_lsb +: fetch_pkg::btb_index_bits];

  assign target_b   = btb_b[pc_idx];
  assign target_jal = btb_jal[pc_idx];

  // ----------------------------------------
  // btfn choice
  // ----------------------------------------

  // only backward targets are taken.
  assign predict_b     = is_branch_b && (target_b < pc);
  assign take_jal      = is_jal && (target_jal < pc);
  assign predict_taken = predict_b || take_jal;

  always_comb begin
    if (predict_b) begin
      pnpc = target_b;
    end else if (take_jal) begin
      pnpc = target_jal;
    end else begin
      pnpc = pc + 32'd4;  // fall through.
    end
  end

  // ----------------------------------------
  // table update on redirect
  // ----------------------------------------

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < fetch_pkg::btb_entries; i++) begin
        btb_b[i]   <= isa_pkg::pc_init;
        btb_jal[i] <= isa_pkg::pc_init;
      end
    end else if (update) begin
      if (update_b) begin
        btb_b[cpc_idx] <= update_target;
      end else begin
        btb_jal[cpc_idx] <= update_target;
      end
    end
  end

endmodule

`default_nettype wire

/* verilog/fetch_pkg.sv */
`default_nettype none

package fetch_pkg;

  // ----------------------------------------
  // branch predictor geometry
  // ----------------------------------------

  localparam int btb_entries = 16;
  localparam int btb_index_bits = 4;
  localparam int btb_index_lsb = 2;  // word aligned pc.

  // ----------------------------------------
  // l1 instruction cache geometry
  // ----------------------------------------

  localparam int cache_lines = 16;  // one word per line.
  localparam int cache_index_bits = 4;
  localparam int cache_index_lsb = 2;
  localparam int cache_tag_lsb = cache_index_lsb + cache_index_bits;
  localparam int cache_tag_bits = isa_pkg::xlen - cache_tag_lsb;  // 26 bits.

  // miss handling fsm.
  typedef enum logic [1:0] {
    lookup,
    request,    // address on the bus.
    wait_data,  // accepted and waiting for rvalid.
    fill        // settle cycle after the line write.
  } cache_state_t;

endpackage

`default_nettype wire

/* verilog/fetch_top.sv */
`default_nettype none

module fetch_top (
  input  wire                      clock,
  input  wire                      reset,
  input  wire  [isa_pkg::xlen-1:0] npc,
  input  wire  [isa_pkg::xlen-1:0] cpc,
  input  wire                      br_retire,
  input  wire                      prev_valid,
  input  wire                      next_ready,
  input  wire                      flush_pipeline,
  input  wire                      fence_i,
  input  wire                      bus_ready,
  input  wire  [isa_pkg::xlen-1:0] bus_rdata,
  input  wire                      bus_rvalid,
  output wire  [isa_pkg::xlen-1:0] inst,
  output wire  [isa_pkg::xlen-1:0] pc,
  output wire  [isa_pkg::xlen-1:0] pnpc,
  output wire                      fetch_valid,
  output wire                      ready,
  output wire  [isa_pkg::xlen-1:0] bus_araddr,
  output wire                      bus_arvalid,
  output wire                      bus_lock
);

  // ----------------------------------------
  // fetch stage
  // ----------------------------------------

  ifu ifu_inst (
    .clock          (clock),
    .reset          (reset),
    .npc            (npc),
    .cpc            (cpc),
    .br_retire      (br_retire),
    .prev_valid     (prev_valid),
    .next_ready     (next_ready),
    .flush_pipeline (flush_pipeline),
    .fence_i        (fence_i),          // drives cache invalidate.
    .bus_ready      (bus_ready),
    .bus_rdata      (bus_rdata),
    .bus_rvalid     (bus_rvalid),
    .inst           (inst),
    .pc             (pc),
    .pnpc           (pnpc),
    .fetch_valid    (fetch_valid),
    .ready          (ready),
    .bus_araddr     (bus_araddr),
    .bus_arvalid    (bus_arvalid),
    .bus_lock       (bus_lock)
  );

endmodule

`default_nettype wire

/* verilog/ifu.sv */
`default_nettype none

module ifu (
  input  wire                      clock,
  input  wire                      reset,
  input  wire  [isa_pkg::xlen-1:0] npc,
  input  wire  [isa_pkg::xlen-1:0] cpc,
  input  wire                      br_retire,
  input  wire                      prev_valid,
  input  wire                      next_ready,
  input  wire                      flush_pipeline,
  input  wire                      fence_i,
  input  wire                      bus_ready,
  input  wire  [isa_pkg::xlen-1:0] bus_rdata,
  input  wire                      bus_rvalid,
  output logic [isa_pkg::xlen-1:0] inst,
  output logic [isa_pkg::xlen-1:0] pc,
  output logic [isa_pkg::xlen-1:0] pnpc,
  output logic                     fetch_valid,
  output logic                     ready,
  output logic [isa_pkg::xlen-1:0] bus_araddr,
  output logic                     bus_arvalid,
  output logic                     bus_lock
);

  logic [isa_pkg::xlen-1:0] pc_q;
  logic [isa_pkg::xlen-1:0] hit_inst;
  logic                     hit_valid;
  isa_pkg::opcode_t         opcode;
  logic                     is_jal;
  logic                     is_branch_b;
  logic                     is_sys;
  logic                     predict_taken;
  logic                     predict_b;
  logic                     sys_hazard_q;  // system inst accepted but not yet retired.
  logic                     spec_b_q;      // outstanding guess came from the branch table.
  logic                     accept;

  // ----------------------------------------
  // pre-decode
  // ----------------------------------------

  assign inst   = hit_valid ? hit_inst : '0;
  assign opcode = isa_pkg::opcode_t'(inst[isa_pkg::opcode_bits-1:0]);

  // jalr is never predicted and steps by 4.
  assign is_jal      = (opcode == isa_pkg::op_jal);
  assign is_branch_b = (opcode == isa_pkg::op_branch);
  assign is_sys      = (opcode == isa_pkg::op_system);

  assign fetch_valid = hit_valid && !sys_hazard_q && !flush_pipeline;
  assign ready       = !fetch_valid;
  assign accept      = fetch_valid && next_ready;
  assign pc          = pc_q;

  // ----------------------------------------
  // pc and speculation state
  // ----------------------------------------

  always_ff @(posedge clock) begin
    if (reset) begin
      pc_q         <= isa_pkg::pc_init;
      sys_hazard_q <= 1'b0;
      spec_b_q     <= 1'b0;
    end else if (flush_pipeline) begin
      pc_q         <= npc;  // redirect from the back end.
      sys_hazard_q <= 1'b0;
      spec_b_q     <= 1'b0;
    end else begin
      if (prev_valid && br_retire) begin
        sys_hazard_q <= 1'b0;
        spec_b_q     <= 1'b0;
        if (sys_hazard_q) begin
          pc_q <= npc;  // resume after the system inst.
        end
      end
      if (accept) begin
        if (is_sys) begin
          sys_hazard_q <= 1'b1;  // pc holds until retire.
        end else if (predict_taken) begin
          pc_q <= pnpc;
        end else begin
          pc_q <= pc_q + 32'd4;
        end
        if (predict_b) begin
          spec_b_q <= 1'b1;
        end
      end
    end
  end

  branch_predictor branch_predictor_inst (
    .clock         (clock),
    .reset         (reset),
    .pc            (pc_q),
    .is_branch_b   (is_branch_b),
    .is_jal        (is_jal),
    .update        (flush_pipeline),
    .update_cpc    (cpc),
    .update_target (npc),
    .update_b      (spec_b_q),
    .pnpc          (pnpc),
    .predict_taken (predict_taken),
    .predict_b     (predict_b)
  );

  l1i_cache l1i_cache_inst (
    .clock          (clock),
    .reset          (reset),
    .pc             (pc_q),
    .invalidate     (fence_i),
    .flush_pipeline (flush_pipeline),
    .bus_ready      (bus_ready),
    .bus_rdata      (bus_rdata),
    .bus_rvalid     (bus_rvalid),
    .hit_inst       (hit_inst),
    .hit_valid      (hit_valid),
    .bus_araddr     (bus_araddr),
    .bus_arvalid    (bus_arvalid),
    .bus_lock       (bus_lock)
  );

endmodule

`default_nettype wire

/* verilog/isa_pkg.sv */
`default_nettype none

package isa_pkg;

  // ----------------------------------------
  // machine word
  // ----------------------------------------

  localparam int xlen = 32;
  localparam logic [xlen-1:0] pc_init = 32'h0000_0000;  // reset vector.

  // ----------------------------------------
  // rv32 major opcodes
  // ----------------------------------------

  localparam int opcode_bits = 7;

  typedef enum logic [opcode_bits-1:0] {
    op_lui    = 7'b0110111,
    op_op_imm = 7'b0010011,
    op_jal    = 7'b1101111,
    op_jalr   = 7'b1100111,
    op_branch = 7'b1100011,  // conditional branches.
    op_system = 7'b1110011   // ecall, ebreak, csr access.
  } opcode_t;

endpackage

`default_nettype wire

/* verilog/l1i_cache.sv */
`default_nettype none

module l1i_cache (
  input  wire                      clock,
  input  wire                      reset,
  input  wire  [isa_pkg::xlen-1:0] pc,
  input  wire                      invalidate,
  input  wire                      flush_pipeline,
  input  wire                      bus_ready,
  input  wire  [isa_pkg::xlen-1:0] bus_rdata,
  input  wire                      bus_rvalid,
  output logic [isa_pkg::xlen-1:0] hit_inst,
  output logic                     hit_valid,
  output logic [isa_pkg::xlen-1:0] bus_araddr,
  output logic                     bus_arvalid,
  output logic                     bus_lock
);

  // ----------------------------------------
  // storage
  // ----------------------------------------

  logic [fetch_pkg::cache_lines-1:0]    valid_q;
  logic [fetch_pkg::cache_tag_bits-1:0] tag_q  [fetch_pkg::cache_lines];
  logic [isa_pkg::xlen-1:0]             data_q [fetch_pkg::cache_lines];

  fetch_pkg::cache_state_t              state_q;
  logic [isa_pkg::xlen-1:0]             miss_addr_q;
  logic                                 drop_fill_q;  // fence_i hit a pending fill.

  logic [fetch_pkg::cache_index_bits-1:0] pc_idx;
  logic [fetch_pkg::cache_index_bits-1:0] fill_idx;
  logic [fetch_pkg::cache_tag_bits-1:0]   pc_tag;
  logic [fetch_pkg::cache_tag_bits-1:0]   fill_tag;
  logic                                   hit;
  logic                                   fill_now;
  logic                                   miss_busy;

  assign pc_idx   = pc[fetch_pkg::cache_index_lsb +: fetch_pkg::cache_index_bits];
  assign pc_tag   = pc[fetch_pkg::cache_tag_lsb +: fetch_pkg::cache_tag_bits];
  assign fill_idx = miss_addr_q[fetch_pkg::cache_index_lsb +: fetch_pkg::cache_index_bits];
  assign fill_tag = miss_addr_q[fetch_pkg::cache_tag_lsb +: fetch_pkg::cache_tag_bits];

  // ----------------------------------------
  // lookup
  // ----------------------------------------

  assign hit       = valid_q[pc_idx] && (tag_q[pc_idx] == pc_tag);
  assign hit_valid = hit && (state_q == fetch_pkg::lookup);
  assign hit_inst  = data_q[pc_idx];

  // ----------------------------------------
  // bus side
  // ----------------------------------------

  assign miss_busy   = (state_q == fetch_pkg::request) || (state_q == fetch_pkg::wait_data);
  assign fill_now    = (state_q == fetch_pkg::wait_data) && bus_rvalid;
  assign bus_araddr  = miss_addr_q;
  assign bus_arvalid = (state_q == fetch_pkg::request);  // held until bus_ready.
  assign bus_lock    = miss_busy;

  // ----------------------------------------
  // miss fsm and valid bits
  // ----------------------------------------

  always_ff @(posedge clock) begin
    if (reset) begin
      state_q     <= fetch_pkg::lookup;
      valid_q     <= '0;
      drop_fill_q <= 1'b0;
    end else begin
      case (state_q)
        fetch_pkg::lookup: begin
          // a redirect or fence this cycle makes the current pc stale.
          if (!hit && !invalidate && !flush_pipeline) begin
            state_q <= fetch_pkg::request;
          end
        end
        fetch_pkg::request: begin
          if (bus_ready) begin
            state_q <= fetch_pkg::wait_data;
          end
        end
        fetch_pkg::wait_data: begin
          if (bus_rvalid) begin
            state_q <= fetch_pkg::fill;
          end
        end
        fetch_pkg::fill: begin
          state_q <= fetch_pkg::lookup;
        end
        default: begin
          state_q <= fetch_pkg::lookup;
        end
      endcase

      if (invalidate) begin
        valid_q <= '0;  // all lines at once.
        if (miss_busy) begin
          drop_fill_q <= 1'b1;
        end
      end

      // the fill always lands, but stays invalid if a fence came in meanwhile.
      if (fill_now) begin
        valid_q[fill_idx] <= !(drop_fill_q || invalidate);
        drop_fill_q       <= 1'b0;
      end
    end
  end

  // ----------------------------------------
  // miss address and line payload
  // ----------------------------------------

  always_ff @(posedge clock) begin
    if ((state_q == fetch_pkg::lookup) && !hit) begin
      miss_addr_q <= {pc[isa_pkg::xlen-1:2], 2'b00};  // word aligned.
    end
    if (fill_now) begin
      data_q[fill_idx] <= bus_rdata;
      tag_q[fill_idx]  <= fill_tag;
    end
  end

endmodule

`default_nettype wire
